// File: lane_params.svh
`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

////////////////////////////////////////
// Lane sizing
////////////////////////////////////////

// Element width in bits
`define LANE_ELEM_W 32

// Vector register file shape
`define LANE_NR_VREGS 8
`define LANE_VLEN 16

////////////////////////////////////////
// Buffer depths
////////////////////////////////////////

`define LANE_OPQ_DEPTH 4
`define LANE_LDQ_DEPTH 4

`endif

// File: lane_pkg.sv
`include "lane_params.svh"

package lane_pkg;

  ////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////

  typedef logic [`LANE_ELEM_W-1:0] elem_t;

  // Register and element addressing
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(`LANE_VLEN)-1:0] eidx_t;

  // One extra bit so a full register length fits
  typedef logic [$clog2(`LANE_VLEN):0] vl_t;

  // Supported operations
  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VSTORE = 3'd5
  } vop_e;

  ////////////////////////////////////////
  // Buffer payloads
  ////////////////////////////////////////

  // Operand pair for one element
  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    eidx_t eidx;
    elem_t opa;
    elem_t opb;
    logic  last;
  } opq_entry_t;

  // Write from the load port
  typedef struct packed {
    vreg_t vreg;
    eidx_t eidx;
    elem_t data;
  } ldq_entry_t;

endpackage

// File: lane_operand_queue.sv
`timescale 1ns/1ps

module lane_operand_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,
  output logic     empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic            ready_q;
  logic            push;
  logic            pop;

  assign push = push_valid_i & ready_q;
  assign pop  = pop_valid_o & pop_ready_i;

  assign empty_o      = (cnt_q == '0);
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push_ready_o = ready_q;

  always_comb begin
    cnt_d = cnt_q;
    if (push && !pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (pop && !push) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q   <= cnt_d;
      ready_q <= (cnt_d != CntW'(Depth));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// File: lane_vrf.sv
`timescale 1ns/1ps

`include "lane_params.svh"

module lane_vrf (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Read port a
  input  lane_pkg::vreg_t      rd_a_vreg_i,
  input  lane_pkg::eidx_t      rd_a_eidx_i,
  output lane_pkg::elem_t      rd_a_data_o,
  // Read port b
  input  lane_pkg::vreg_t      rd_b_vreg_i,
  input  lane_pkg::eidx_t      rd_b_eidx_i,
  output lane_pkg::elem_t      rd_b_data_o,
  // ALU write
  input  logic                 alu_we_i,
  input  lane_pkg::vreg_t      alu_vreg_i,
  input  lane_pkg::eidx_t      alu_eidx_i,
  input  lane_pkg::elem_t      alu_data_i,
  // Load buffer write
  input  logic                 ld_valid_i,
  input  lane_pkg::ldq_entry_t ld_entry_i,
  output logic                 ld_ready_o
);

  import lane_pkg::*;

  elem_t regs_q [`LANE_NR_VREGS][`LANE_VLEN];

  logic  we;
  vreg_t wr_vreg;
  eidx_t wr_eidx;
  elem_t wr_data;

  // Combinational reads
  assign rd_a_data_o = regs_q[rd_a_vreg_i][rd_a_eidx_i];
  assign rd_b_data_o = regs_q[rd_b_vreg_i][rd_b_eidx_i];

  ////////////////////////////////////////
  // Write arbitration
  ////////////////////////////////////////

  // Load buffer only gets the port when the ALU is quiet
  assign ld_ready_o = ~alu_we_i;

  always_comb begin
    we      = alu_we_i | ld_valid_i;
    wr_vreg = ld_entry_i.vreg;
    wr_eidx = ld_entry_i.eidx;
    wr_data = ld_entry_i.data;
    if (alu_we_i) begin
      wr_vreg = alu_vreg_i;
      wr_eidx = alu_eidx_i;
      wr_data = alu_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < `LANE_NR_VREGS; r++) begin
        for (int e = 0; e < `LANE_VLEN; e++) begin
          regs_q[r][e] <= '0;
        end
      end
    end else if (we) begin
      regs_q[wr_vreg][wr_eidx] <= wr_data;
    end
  end

endmodule

// File: lane_operand_requester.sv
`timescale 1ns/1ps

module lane_operand_requester (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Command port
  input  logic                 cmd_valid_i,
  input  lane_pkg::vop_e       cmd_op_i,
  input  lane_pkg::vreg_t      cmd_vd_i,
  input  lane_pkg::vreg_t      cmd_vs1_i,
  input  lane_pkg::vreg_t      cmd_vs2_i,
  input  lane_pkg::vl_t        cmd_vl_i,
  output logic                 cmd_ready_o,
  // Lane status
  input  logic                 ldq_empty_i,
  input  logic                 alu_busy_i,
  // VRF read ports
  output lane_pkg::vreg_t      rd_a_vreg_o,
  output lane_pkg::eidx_t      rd_a_eidx_o,
  input  lane_pkg::elem_t      rd_a_data_i,
  output lane_pkg::vreg_t      rd_b_vreg_o,
  output lane_pkg::eidx_t      rd_b_eidx_o,
  input  lane_pkg::elem_t      rd_b_data_i,
  // Operand queue push
  output logic                 opq_valid_o,
  output lane_pkg::opq_entry_t opq_data_o,
  input  logic                 opq_ready_i
);

  import lane_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e state_q;
  eidx_t  eidx_q;

  // Latched command
  vop_e  op_q;
  vreg_t vd_q;
  vreg_t vs1_q;
  vreg_t vs2_q;
  vl_t   vl_q;

  logic cmd_hs;
  logic push;
  logic last;

  // Only one instruction in flight, and pending loads must land first
  assign cmd_ready_o = (state_q == IDLE) & ~alu_busy_i & ldq_empty_i;
  assign cmd_hs      = cmd_valid_i & cmd_ready_o;
  assign push        = opq_valid_o & opq_ready_i;

  // A zero length also ends after one element
  assign last = (vl_t'(eidx_q) + vl_t'(1)) >= vl_q;

  always_ff @(posedge clk_i) begin
    if (cmd_hs) begin
      op_q  <= cmd_op_i;
      vd_q  <= cmd_vd_i;
      vs1_q <= cmd_vs1_i;
      vs2_q <= cmd_vs2_i;
      vl_q  <= cmd_vl_i;
    end
  end

  ////////////////////////////////////////
  // Element walk
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      eidx_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cmd_hs) begin
            state_q <= RUN;
            eidx_q  <= '0;
          end
        end
        RUN: begin
          if (push) begin
            if (last) begin
              state_q <= IDLE;
            end else begin
              eidx_q <= eidx_q + 1'b1;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Both sources read at the current index
  assign rd_a_vreg_o = vs1_q;
  assign rd_a_eidx_o = eidx_q;
  assign rd_b_vreg_o = vs2_q;
  assign rd_b_eidx_o = eidx_q;

  assign opq_valid_o = (state_q == RUN);

  always_comb begin
    opq_data_o.op   = op_q;
    opq_data_o.vd   = vd_q;
    opq_data_o.eidx = eidx_q;
    opq_data_o.opa  = rd_a_data_i;
    opq_data_o.opb  = rd_b_data_i;
    opq_data_o.last = last;
  end

endmodule

// File: lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Operand queue pop
  input  logic                 opq_valid_i,
  input  lane_pkg::opq_entry_t opq_data_i,
  output logic                 opq_ready_o,
  // VRF write
  output logic                 alu_we_o,
  output lane_pkg::vreg_t      alu_vreg_o,
  output lane_pkg::eidx_t      alu_eidx_o,
  output lane_pkg::elem_t      alu_data_o,
  // Store operand port
  output logic                 st_valid_o,
  output lane_pkg::elem_t      st_data_o,
  input  logic                 st_ready_i,
  // Status
  output logic                 busy_o,
  output logic                 done_o
);

  import lane_pkg::*;

  elem_t result;
  elem_t st_data_q;
  logic  st_valid_q;
  logic  st_last_q;
  logic  busy_q;
  logic  done_q;
  logic  is_store;
  logic  pop;
  logic  st_hs;
  logic  retire;

  assign is_store = (opq_data_i.op == VSTORE);

  // Stores wait for room in the output register
  assign opq_ready_o = is_store ? (~st_valid_q | st_ready_i) : 1'b1;
  assign pop         = opq_valid_i & opq_ready_o;
  assign st_hs       = st_valid_q & st_ready_i;

  always_comb begin
    case (opq_data_i.op)
      VADD:    result = opq_data_i.opa + opq_data_i.opb;
      VSUB:    result = opq_data_i.opa - opq_data_i.opb;
      VAND:    result = opq_data_i.opa & opq_data_i.opb;
      VOR:     result = opq_data_i.opa | opq_data_i.opb;
      VXOR:    result = opq_data_i.opa ^ opq_data_i.opb;
      default: result = opq_data_i.opb;
    endcase
  end

  // Write back in the pop cycle
  assign alu_we_o   = pop & ~is_store;
  assign alu_vreg_o = opq_data_i.vd;
  assign alu_eidx_o = opq_data_i.eidx;
  assign alu_data_o = result;

  ////////////////////////////////////////
  // Store output and retirement
  ////////////////////////////////////////

  // Last element written, or last store element taken
  assign retire = (alu_we_o & opq_data_i.last) | (st_hs & st_last_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_valid_q <= 1'b0;
      st_last_q  <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      if (pop && is_store) begin
        st_valid_q <= 1'b1;
        st_last_q  <= opq_data_i.last;
      end else if (st_hs) begin
        st_valid_q <= 1'b0;
      end
      if (retire) begin
        busy_q <= 1'b0;
      end else if (pop) begin
        busy_q <= 1'b1;
      end
      done_q <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop && is_store) begin
      st_data_q <= opq_data_i.opb;
    end
  end

  assign st_valid_o = st_valid_q;
  assign st_data_o  = st_data_q;
  // Queued entries count as busy before their first pop
  assign busy_o     = busy_q | opq_valid_i;
  assign done_o     = done_q;

endmodule

// File: lane.sv
`timescale 1ns/1ps

`include "lane_params.svh"

module lane (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Command port
  input  logic            cmd_valid_i,
  input  lane_pkg::vop_e  cmd_op_i,
  input  lane_pkg::vreg_t cmd_vd_i,
  input  lane_pkg::vreg_t cmd_vs1_i,
  input  lane_pkg::vreg_t cmd_vs2_i,
  input  lane_pkg::vl_t   cmd_vl_i,
  output logic            cmd_ready_o,
  output logic            done_o,
  // Load port
  input  logic            ld_valid_i,
  input  lane_pkg::vreg_t ld_vreg_i,
  input  lane_pkg::eidx_t ld_eidx_i,
  input  lane_pkg::elem_t ld_data_i,
  output logic            ld_ready_o,
  // Store port
  output logic            st_valid_o,
  output lane_pkg::elem_t st_data_o,
  input  logic            st_ready_i
);

  import lane_pkg::*;

  // Requester to VRF
  vreg_t rd_a_vreg;
  eidx_t rd_a_eidx;
  elem_t rd_a_data;
  vreg_t rd_b_vreg;
  eidx_t rd_b_eidx;
  elem_t rd_b_data;

  // Operand queue
  logic       opq_push_valid;
  opq_entry_t opq_push_data;
  logic       opq_push_ready;
  logic       opq_pop_valid;
  opq_entry_t opq_pop_data;
  logic       opq_pop_ready;

  // Load buffer
  ldq_entry_t ldq_push_data;
  logic       ldq_pop_valid;
  ldq_entry_t ldq_pop_data;
  logic       ldq_pop_ready;
  logic       ldq_empty;

  // ALU side
  logic  alu_we;
  vreg_t alu_vreg;
  eidx_t alu_eidx;
  elem_t alu_data;
  logic  alu_busy;

  assign ldq_push_data = '{vreg: ld_vreg_i, eidx: ld_eidx_i, data: ld_data_i};

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  lane_operand_requester u_requester (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_vd_i    (cmd_vd_i),
    .cmd_vs1_i   (cmd_vs1_i),
    .cmd_vs2_i   (cmd_vs2_i),
    .cmd_vl_i    (cmd_vl_i),
    .cmd_ready_o (cmd_ready_o),
    .ldq_empty_i (ldq_empty),
    .alu_busy_i  (alu_busy),
    .rd_a_vreg_o (rd_a_vreg),
    .rd_a_eidx_o (rd_a_eidx),
    .rd_a_data_i (rd_a_data),
    .rd_b_vreg_o (rd_b_vreg),
    .rd_b_eidx_o (rd_b_eidx),
    .rd_b_data_i (rd_b_data),
    .opq_valid_o (opq_push_valid),
    .opq_data_o  (opq_push_data),
    .opq_ready_i (opq_push_ready)
  );

  lane_operand_queue #(
    .payload_t (opq_entry_t),
    .Depth     (`LANE_OPQ_DEPTH)
  ) u_opq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (opq_push_valid),
    .push_data_i  (opq_push_data),
    .push_ready_o (opq_push_ready),
    .pop_valid_o  (opq_pop_valid),
    .pop_data_o   (opq_pop_data),
    .pop_ready_i  (opq_pop_ready),
    .empty_o      ()
  );

  // Load buffer drains into the VRF write port
  lane_operand_queue #(
    .payload_t (ldq_entry_t),
    .Depth     (`LANE_LDQ_DEPTH)
  ) u_ldq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (ld_valid_i),
    .push_data_i  (ldq_push_data),
    .push_ready_o (ld_ready_o),
    .pop_valid_o  (ldq_pop_valid),
    .pop_data_o   (ldq_pop_data),
    .pop_ready_i  (ldq_pop_ready),
    .empty_o      (ldq_empty)
  );

  lane_alu u_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .opq_valid_i (opq_pop_valid),
    .opq_data_i  (opq_pop_data),
    .opq_ready_o (opq_pop_ready),
    .alu_we_o    (alu_we),
    .alu_vreg_o  (alu_vreg),
    .alu_eidx_o  (alu_eidx),
    .alu_data_o  (alu_data),
    .st_valid_o  (st_valid_o),
    .st_data_o   (st_data_o),
    .st_ready_i  (st_ready_i),
    .busy_o      (alu_busy),
    .done_o      (done_o)
  );

  lane_vrf u_vrf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_a_vreg_i (rd_a_vreg),
    .rd_a_eidx_i (rd_a_eidx),
    .rd_a_data_o (rd_a_data),
    .rd_b_vreg_i (rd_b_vreg),
    .rd_b_eidx_i (rd_b_eidx),
    .rd_b_data_o (rd_b_data),
    .alu_we_i    (alu_we),
    .alu_vreg_i  (alu_vreg),
    .alu_eidx_i  (alu_eidx),
    .alu_data_i  (alu_data),
    .ld_valid_i  (ldq_pop_valid),
    .ld_entry_i  (ldq_pop_data),
    .ld_ready_o  (ldq_pop_ready)
  );

endmodule

// File: lane_tb.sv
`timescale 1ns/1ps

`include "lane_params.svh"

module lane_tb;

  import lane_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_ARITH    = 40;
  localparam int N_ORDER    = 20;
  localparam int MAX_LOADS  = 4;

  // Stores of every register in tests 2, 4 and the final sweep, plus the command pairs
  localparam int NUM_CMDS  = 3 * `LANE_NR_VREGS + 2 * N_ARITH + 2 * N_ORDER;
  localparam int NUM_LOADS = `LANE_NR_VREGS * `LANE_VLEN + N_ORDER * MAX_LOADS;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 200 + NUM_LOADS * 20 + 20;

  logic  clk_i;
  logic  rst_ni;
  logic  cmd_valid_i;
  vop_e  cmd_op_i;
  vreg_t cmd_vd_i;
  vreg_t cmd_vs1_i;
  vreg_t cmd_vs2_i;
  vl_t   cmd_vl_i;
  logic  cmd_ready_o;
  logic  done_o;
  logic  ld_valid_i;
  vreg_t ld_vreg_i;
  eidx_t ld_eidx_i;
  elem_t ld_data_i;
  logic  ld_ready_o;
  logic  st_valid_o;
  elem_t st_data_o;
  logic  st_ready_i;

  // Reference copy of the register file
  elem_t model [`LANE_NR_VREGS][`LANE_VLEN];
  string test_name;

  lane u_lane (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_vd_i    (cmd_vd_i),
    .cmd_vs1_i   (cmd_vs1_i),
    .cmd_vs2_i   (cmd_vs2_i),
    .cmd_vl_i    (cmd_vl_i),
    .cmd_ready_o (cmd_ready_o),
    .done_o      (done_o),
    .ld_valid_i  (ld_valid_i),
    .ld_vreg_i   (ld_vreg_i),
    .ld_eidx_i   (ld_eidx_i),
    .ld_data_i   (ld_data_i),
    .ld_ready_o  (ld_ready_o),
    .st_valid_o  (st_valid_o),
    .st_data_o   (st_data_o),
    .st_ready_i  (st_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the lane stopped making progress before all tests finished");
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic show_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s: %s expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    abort_run();
  endtask

  task automatic show_problem(input string msg);
    $display("Error in %s: %s", test_name, msg);
    abort_run();
  endtask

  // Wrapping 32-bit element arithmetic
  function automatic elem_t expected_result(input vop_e op, input elem_t a, input elem_t b);
    case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      VXOR:    return a ^ b;
      default: return b;
    endcase
  endfunction

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // Called 1 ns after a rising edge, returns at the same phase
  task automatic issue_load(input vreg_t r, input eidx_t e, input elem_t d);
    bit accepted;
    accepted   = 1'b0;
    ld_valid_i = 1'b1;
    ld_vreg_i  = r;
    ld_eidx_i  = e;
    ld_data_i  = d;
    while (!accepted) begin
      @(negedge clk_i);
      assert (!done_o)
        else show_problem("done_o pulsed with no instruction in flight");
      accepted = ld_ready_o;
      @(posedge clk_i);
      #1;
    end
    ld_valid_i = 1'b0;
    model[r][e] = d;
  endtask

  task automatic run_command(input vop_e op, input vreg_t vd, input vreg_t vs1,
                             input vreg_t vs2, input vl_t vl, input bit bp);
    int n_st;
    bit accepted;
    bit seen_done;
    n_st        = 0;
    accepted    = 1'b0;
    seen_done   = 1'b0;
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_vd_i    = vd;
    cmd_vs1_i   = vs1;
    cmd_vs2_i   = vs2;
    cmd_vl_i    = vl;
    st_ready_i  = bp ? 1'($urandom_range(0, 1)) : 1'b1;
    while (!accepted) begin
      @(negedge clk_i);
      assert (!done_o)
        else show_problem("done_o pulsed with no instruction in flight");
      accepted = cmd_ready_o;
      @(posedge clk_i);
      #1;
    end
    cmd_valid_i = 1'b0;
    // Follow the instruction until its done pulse
    while (!seen_done) begin
      @(negedge clk_i);
      if (st_valid_o && st_ready_i) begin
        assert (op == VSTORE)
          else show_problem("store data appeared during an arithmetic instruction");
        assert (n_st < int'(vl))
          else show_problem("more store elements than the vector length");
        assert (st_data_o == model[vs2][n_st])
          else show_mismatch($sformatf("v%0d[%0d]", vs2, n_st), model[vs2][n_st], st_data_o);
        n_st++;
      end
      if (done_o) begin
        seen_done = 1'b1;
      end else begin
        assert (!cmd_ready_o)
          else show_problem("cmd_ready_o went high before the done pulse");
      end
      @(posedge clk_i);
      #1;
      st_ready_i = bp ? 1'($urandom_range(0, 1)) : 1'b1;
    end
    @(negedge clk_i);
    assert (!done_o)
      else show_problem("done_o stayed high for more than one cycle");
    if (op == VSTORE) begin
      assert (n_st == int'(vl))
        else show_mismatch("store element count", int'(vl), n_st);
    end else begin
      for (int i = 0; i < int'(vl); i++) begin
        model[vd][i] = expected_result(op, model[vs1][i], model[vs2][i]);
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic store_all_regs(input bit bp);
    for (int r = 0; r < `LANE_NR_VREGS; r++) begin
      run_command(VSTORE, '0, '0, vreg_t'(r), vl_t'(`LANE_VLEN), bp);
    end
  endtask

  function automatic vop_e random_op();
    return vop_e'($urandom_range(0, 4));
  endfunction

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    vop_e  op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    vl_t   vl;
    int    n_ld;
    void'($urandom(32'h80fa9731));
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = VADD;
    cmd_vd_i    = '0;
    cmd_vs1_i   = '0;
    cmd_vs2_i   = '0;
    cmd_vl_i    = '0;
    ld_valid_i  = 1'b0;
    ld_vreg_i   = '0;
    ld_eidx_i   = '0;
    ld_data_i   = '0;
    st_ready_i  = 1'b0;
    for (int r = 0; r < `LANE_NR_VREGS; r++) begin
      for (int e = 0; e < `LANE_VLEN; e++) begin
        model[r][e] = '0;
      end
    end

    test_name = "reset_state";
    @(negedge clk_i);
    assert (!ld_ready_o) else show_mismatch("ld_ready_o in reset", 0, ld_ready_o);
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (cmd_ready_o) else show_mismatch("cmd_ready_o", 1, cmd_ready_o);
    assert (!done_o) else show_mismatch("done_o", 0, done_o);
    assert (!st_valid_o) else show_mismatch("st_valid_o", 0, st_valid_o);
    assert (!ld_ready_o) else show_mismatch("ld_ready_o", 0, ld_ready_o);
    @(posedge clk_i);
    #1;

    test_name = "load_store_round_trip";
    for (int r = 0; r < `LANE_NR_VREGS; r++) begin
      for (int e = 0; e < `LANE_VLEN; e++) begin
        issue_load(vreg_t'(r), eidx_t'(e), $urandom());
      end
    end
    store_all_regs(1'b0);

    test_name = "random_arithmetic";
    for (int n = 0; n < N_ARITH; n++) begin
      op = random_op();
      vd = vreg_t'($urandom_range(0, `LANE_NR_VREGS - 1));
      vs1 = vreg_t'($urandom_range(0, `LANE_NR_VREGS - 1));
      vs2 = vreg_t'($urandom_range(0, `LANE_NR_VREGS - 1));
      vl = vl_t'($urandom_range(1, `LANE_VLEN));
      run_command(op, vd, vs1, vs2, vl, 1'b0);
      run_command(VSTORE, '0, '0, vd, vl_t'(`LANE_VLEN), 1'b0);
    end

    test_name = "store_back_pressure";
    store_all_regs(1'b1);

    // Loads land on the sources right before each command
    test_name = "load_ordering";
    for (int n = 0; n < N_ORDER; n++) begin
      op = random_op();
      vd = vreg_t'($urandom_range(0, `LANE_NR_VREGS - 1));
      vs1 = vreg_t'($urandom_range(0, `LANE_NR_VREGS - 1));
      vs2 = vreg_t'($urandom_range(0, `LANE_NR_VREGS - 1));
      vl = vl_t'($urandom_range(1, `LANE_VLEN));
      n_ld = $urandom_range(1, MAX_LOADS);
      for (int k = 0; k < n_ld; k++) begin
        issue_load((k % 2 == 0) ? vs1 : vs2, eidx_t'($urandom_range(0, int'(vl) - 1)),
                   $urandom());
      end
      run_command(op, vd, vs1, vs2, vl, 1'b1);
      run_command(VSTORE, '0, '0, vd, vl_t'(`LANE_VLEN), 1'b1);
    end

    test_name = "final_sweep";
    store_all_regs(1'b1);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: lane.f
+incdir+.
lane_pkg.sv
lane_operand_queue.sv
lane_vrf.sv
lane_operand_requester.sv
lane_alu.sv
lane.sv
lane_tb.sv
